/* exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Data, PC and instruction width
`define EXEC_WORD_W 16

// Opcode field sits in the top bits of the instruction
`define EXEC_OPC_W 5

// rs and rt fields are 3 bits wide
`define EXEC_NUM_REGS 8

// Input strobe to output strobe, in cycles
`define EXEC_LATENCY 2

`endif

/* isa_pkg.sv */
`default_nettype none

`include "exec_settings.svh"

package isa_pkg;

  typedef logic [`EXEC_WORD_W-1:0] word_t;
  typedef logic [`EXEC_OPC_W-1:0]  opcode_t;
  typedef logic [1:0]              funct_t;

  // Major opcodes, instr[15:11]
  localparam opcode_t OPC_NOP   = 5'b00001;
  localparam opcode_t OPC_J     = 5'b00100;
  localparam opcode_t OPC_JR    = 5'b00101;
  localparam opcode_t OPC_ADDI  = 5'b01000;
  localparam opcode_t OPC_SUBI  = 5'b01001;
  localparam opcode_t OPC_XORI  = 5'b01010;
  localparam opcode_t OPC_ANDNI = 5'b01011;
  localparam opcode_t OPC_BEQZ  = 5'b01100;
  localparam opcode_t OPC_BNEZ  = 5'b01101;
  localparam opcode_t OPC_BLTZ  = 5'b01110;
  localparam opcode_t OPC_BGEZ  = 5'b01111;
  localparam opcode_t OPC_SLBI  = 5'b10010;
  localparam opcode_t OPC_ROLI  = 5'b10100;
  localparam opcode_t OPC_SLLI  = 5'b10101;
  localparam opcode_t OPC_RORI  = 5'b10110;
  localparam opcode_t OPC_SRLI  = 5'b10111;
  localparam opcode_t OPC_LBI   = 5'b11000;
  localparam opcode_t OPC_SHIFT = 5'b11010;
  localparam opcode_t OPC_ARITH = 5'b11011;
  localparam opcode_t OPC_SEQ   = 5'b11100;
  localparam opcode_t OPC_SLT   = 5'b11101;
  localparam opcode_t OPC_SLE   = 5'b11110;
  localparam opcode_t OPC_SCO   = 5'b11111;

  // Function field, instr[1:0], for OPC_ARITH
  localparam funct_t FN_ADD  = 2'b00;
  localparam funct_t FN_SUB  = 2'b01;
  localparam funct_t FN_XOR  = 2'b10;
  localparam funct_t FN_ANDN = 2'b11;

  // Same field for OPC_SHIFT
  localparam funct_t FN_ROL  = 2'b00;
  localparam funct_t FN_SLL  = 2'b01;
  localparam funct_t FN_ROR  = 2'b10;
  localparam funct_t FN_SRL  = 2'b11;

endpackage

`default_nettype wire

/* ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

  typedef logic [2:0] alu_op_t;
  typedef logic [2:0] src_sel_t;
  typedef logic [1:0] cond_t;
  typedef logic [2:0] pc_src_t;
  typedef logic [1:0] brc_t;

  localparam alu_op_t ALU_ROL  = 3'd0;
  localparam alu_op_t ALU_SLL  = 3'd1;
  localparam alu_op_t ALU_ROR  = 3'd2;
  localparam alu_op_t ALU_SRL  = 3'd3;
  localparam alu_op_t ALU_ADD  = 3'd4;
  localparam alu_op_t ALU_OR   = 3'd5;
  localparam alu_op_t ALU_XOR  = 3'd6;
  localparam alu_op_t ALU_ANDN = 3'd7;

  // One code space, each operand mux honours its own subset
  localparam src_sel_t SRC_RS      = 3'd0;
  localparam src_sel_t SRC_RS_SHL8 = 3'd1;
  localparam src_sel_t SRC_RT      = 3'd2;
  localparam src_sel_t SRC_IMM5    = 3'd3;
  localparam src_sel_t SRC_IMM8    = 3'd4;
  localparam src_sel_t SRC_ZERO    = 3'd5;

  // Matches opcode[1:0] of SEQ, SLT, SLE, SCO
  localparam cond_t COND_EQ = 2'd0;
  localparam cond_t COND_LT = 2'd1;
  localparam cond_t COND_LE = 2'd2;
  localparam cond_t COND_CO = 2'd3;

  localparam pc_src_t PC_SEQ       = 3'd0;
  localparam pc_src_t PC_BR_IMM8   = 3'd1;
  localparam pc_src_t PC_JMP_IMM11 = 3'd2;
  localparam pc_src_t PC_REG_IMM8  = 3'd3;

  // Matches opcode[1:0] of BEQZ, BNEZ, BLTZ, BGEZ
  localparam brc_t BRC_EQZ = 2'd0;
  localparam brc_t BRC_NEZ = 2'd1;
  localparam brc_t BRC_LTZ = 2'd2;
  localparam brc_t BRC_GEZ = 2'd3;

endpackage

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module alu (
  input  isa_pkg::word_t    a,
  input  isa_pkg::word_t    b,
  input  ctrl_pkg::alu_op_t op,
  input  logic              cin,
  input  logic              inv_a,
  input  logic              inv_b,
  input  logic              sign,
  output isa_pkg::word_t    out,
  output logic              zero,
  output logic              cout,
  output logic              ofl
);

  isa_pkg::word_t              aa;
  isa_pkg::word_t              bb;
  isa_pkg::word_t              sum;
  logic [3:0]                  amt;
  logic [2*`EXEC_WORD_W-1:0]   rol_w;
  logic [2*`EXEC_WORD_W-1:0]   ror_w;
  logic                        s_ofl;

  assign aa = inv_a ? ~a : a;
  assign bb = inv_b ? ~b : b;

  // Shift amount is the low nibble of operand b
  assign amt = bb[3:0];

  // Rotates through a doubled copy of the operand
  assign rol_w = {aa, aa} << amt;
  assign ror_w = {aa, aa} >> amt;

  assign {cout, sum} = {1'b0, aa} + {1'b0, bb} + {{`EXEC_WORD_W{1'b0}}, cin};

  // Signed overflow when both inputs agree in sign and the sum does not
  assign s_ofl = (aa[`EXEC_WORD_W-1] == bb[`EXEC_WORD_W-1]) &&
                 (sum[`EXEC_WORD_W-1] != aa[`EXEC_WORD_W-1]);
  assign ofl   = sign ? s_ofl : cout;
  assign zero  = (sum == '0);

  always_comb begin
    case (op)
      ctrl_pkg::ALU_ROL:  out = rol_w[2*`EXEC_WORD_W-1:`EXEC_WORD_W];
      ctrl_pkg::ALU_SLL:  out = aa << amt;
      ctrl_pkg::ALU_ROR:  out = ror_w[`EXEC_WORD_W-1:0];
      ctrl_pkg::ALU_SRL:  out = aa >> amt;
      ctrl_pkg::ALU_ADD:  out = sum;
      ctrl_pkg::ALU_OR:   out = aa | bb;
      ctrl_pkg::ALU_XOR:  out = aa ^ bb;
      ctrl_pkg::ALU_ANDN: out = aa & ~bb;
      default:            out = sum;
    endcase
  end

endmodule

`default_nettype wire

/* decode_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module decode_ctrl (
  input  isa_pkg::word_t     instr,
  output ctrl_pkg::alu_op_t  alu_op,
  output ctrl_pkg::src_sel_t src_a,
  output ctrl_pkg::src_sel_t src_b,
  output logic               cin,
  output logic               inv_a,
  output logic               inv_b,
  output logic               is_set,
  output ctrl_pkg::cond_t    cond,
  output ctrl_pkg::pc_src_t  pc_src,
  output logic               is_branch,
  output ctrl_pkg::brc_t     brc,
  output isa_pkg::word_t     imm5_ext,
  output isa_pkg::word_t     imm8_ext,
  output isa_pkg::word_t     imm11_ext,
  output logic               active
);

  isa_pkg::opcode_t opc;
  isa_pkg::funct_t  fn;
  logic             imm5_signed;
  logic             imm5_shamt;
  logic             imm8_signed;

  // Register and immediate shifts share this ordering
  function automatic ctrl_pkg::alu_op_t shift_op(input isa_pkg::funct_t f);
    case (f)
      isa_pkg::FN_ROL: shift_op = ctrl_pkg::ALU_ROL;
      isa_pkg::FN_SLL: shift_op = ctrl_pkg::ALU_SLL;
      isa_pkg::FN_ROR: shift_op = ctrl_pkg::ALU_ROR;
      isa_pkg::FN_SRL: shift_op = ctrl_pkg::ALU_SRL;
    endcase
  endfunction

  assign opc = instr[`EXEC_WORD_W-1 -: `EXEC_OPC_W];
  assign fn  = instr[1:0];

  always_comb begin
    alu_op      = ctrl_pkg::ALU_ADD;
    src_a       = ctrl_pkg::SRC_RS;
    src_b       = ctrl_pkg::SRC_RT;
    {inv_a, inv_b, cin} = 3'b000;
    is_set      = 1'b0;
    is_branch   = 1'b0;
    pc_src      = ctrl_pkg::PC_SEQ;
    // Set and branch tests come straight from the opcode low bits
    cond        = ctrl_pkg::cond_t'(opc[1:0]);
    brc         = ctrl_pkg::brc_t'(opc[1:0]);
    imm5_signed = 1'b0;
    imm5_shamt  = 1'b0;
    imm8_signed = 1'b1;
    active      = 1'b1;
    case (opc)
      isa_pkg::OPC_ARITH: begin
        case (fn)
          isa_pkg::FN_ADD:  alu_op = ctrl_pkg::ALU_ADD;
          // rt - rs as ~rs + rt + 1
          isa_pkg::FN_SUB:  {inv_a, cin} = 2'b11;
          isa_pkg::FN_XOR:  alu_op = ctrl_pkg::ALU_XOR;
          isa_pkg::FN_ANDN: alu_op = ctrl_pkg::ALU_ANDN;
        endcase
      end
      isa_pkg::OPC_ADDI:  {src_b, imm5_signed} = {ctrl_pkg::SRC_IMM5, 1'b1};
      isa_pkg::OPC_SUBI:  {src_b, imm5_signed, inv_a, cin} = {ctrl_pkg::SRC_IMM5, 3'b111};
      isa_pkg::OPC_XORI:  {alu_op, src_b} = {ctrl_pkg::ALU_XOR, ctrl_pkg::SRC_IMM5};
      isa_pkg::OPC_ANDNI: {alu_op, src_b} = {ctrl_pkg::ALU_ANDN, ctrl_pkg::SRC_IMM5};
      isa_pkg::OPC_SHIFT: alu_op = shift_op(fn);
      isa_pkg::OPC_ROLI, isa_pkg::OPC_SLLI, isa_pkg::OPC_RORI, isa_pkg::OPC_SRLI: begin
        alu_op = shift_op(opc[1:0]);
        {src_b, imm5_shamt} = {ctrl_pkg::SRC_IMM5, 1'b1};
      end
      isa_pkg::OPC_LBI: begin
        alu_op = ctrl_pkg::ALU_OR;
        {src_a, src_b} = {ctrl_pkg::SRC_ZERO, ctrl_pkg::SRC_IMM8};
      end
      isa_pkg::OPC_SLBI: begin
        alu_op = ctrl_pkg::ALU_OR;
        {src_a, src_b, imm8_signed} = {ctrl_pkg::SRC_RS_SHL8, ctrl_pkg::SRC_IMM8, 1'b0};
      end
      // rs - rt for the compares
      isa_pkg::OPC_SEQ, isa_pkg::OPC_SLT, isa_pkg::OPC_SLE: {is_set, inv_b, cin} = 3'b111;
      // Plain rs + rt, only the carry matters
      isa_pkg::OPC_SCO:   is_set = 1'b1;
      isa_pkg::OPC_BEQZ, isa_pkg::OPC_BNEZ, isa_pkg::OPC_BLTZ, isa_pkg::OPC_BGEZ: begin
        {is_branch, pc_src} = {1'b1, ctrl_pkg::PC_BR_IMM8};
      end
      isa_pkg::OPC_J:     pc_src = ctrl_pkg::PC_JMP_IMM11;
      isa_pkg::OPC_JR:    pc_src = ctrl_pkg::PC_REG_IMM8;
      isa_pkg::OPC_NOP:   active = 1'b0;
      default:            active = 1'b0;
    endcase
  end

  // Immediate shifts use only imm5[3:0]
  assign imm5_ext  = imm5_shamt  ? {{(`EXEC_WORD_W-4){1'b0}}, instr[3:0]} :
                     imm5_signed ? {{(`EXEC_WORD_W-5){instr[4]}}, instr[4:0]} :
                                   {{(`EXEC_WORD_W-5){1'b0}}, instr[4:0]};
  assign imm8_ext  = imm8_signed ? {{(`EXEC_WORD_W-8){instr[7]}}, instr[7:0]} :
                                   {{(`EXEC_WORD_W-8){1'b0}}, instr[7:0]};
  assign imm11_ext = {{(`EXEC_WORD_W-11){instr[10]}}, instr[10:0]};

endmodule

`default_nettype wire

/* id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  ctrl_pkg::alu_op_t  alu_op,
  input  ctrl_pkg::src_sel_t src_a, src_b,
  input  logic               cin, inv_a, inv_b, is_set, is_branch, active,
  input  ctrl_pkg::cond_t    cond,
  input  ctrl_pkg::pc_src_t  pc_src,
  input  ctrl_pkg::brc_t     brc,
  input  isa_pkg::word_t     imm5_ext, imm8_ext, imm11_ext,
  input  isa_pkg::word_t     pc, rs_data, rt_data,
  output logic               ex_valid,
  output ctrl_pkg::alu_op_t  ex_alu_op,
  output ctrl_pkg::src_sel_t ex_src_a, ex_src_b,
  output logic               ex_cin, ex_inv_a, ex_inv_b, ex_is_set, ex_is_branch, ex_active,
  output ctrl_pkg::cond_t    ex_cond,
  output ctrl_pkg::pc_src_t  ex_pc_src,
  output ctrl_pkg::brc_t     ex_brc,
  output isa_pkg::word_t     ex_imm5_ext, ex_imm8_ext, ex_imm11_ext,
  output isa_pkg::word_t     ex_pc, ex_rs_data, ex_rt_data
);

  // Control word, cleared so a reset bubble is inert
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
      {ex_alu_op, ex_src_a, ex_src_b, ex_cond, ex_pc_src, ex_brc} <= '0;
      {ex_cin, ex_inv_a, ex_inv_b, ex_is_set, ex_is_branch, ex_active} <= '0;
    end else begin
      ex_valid <= in_valid;
      {ex_alu_op, ex_src_a, ex_src_b, ex_cond, ex_pc_src, ex_brc} <=
        {alu_op, src_a, src_b, cond, pc_src, brc};
      {ex_cin, ex_inv_a, ex_inv_b, ex_is_set, ex_is_branch, ex_active} <=
        {cin, inv_a, inv_b, is_set, is_branch, active};
    end
  end

  // Operands and immediates
  always_ff @(posedge clk) begin
    ex_imm5_ext  <= imm5_ext;
    ex_imm8_ext  <= imm8_ext;
    ex_imm11_ext <= imm11_ext;
    ex_pc        <= pc;
    ex_rs_data   <= rs_data;
    ex_rt_data   <= rt_data;
  end

endmodule

`default_nettype wire

/* execution.sv */
`timescale 1ns/1ps
`default_nettype none

module execution (
  input  logic               clk,
  input  logic               rst,
  input  logic               ex_valid,
  input  ctrl_pkg::alu_op_t  ex_alu_op,
  input  ctrl_pkg::src_sel_t ex_src_a, ex_src_b,
  input  logic               ex_cin, ex_inv_a, ex_inv_b, ex_is_set, ex_is_branch, ex_active,
  input  ctrl_pkg::cond_t    ex_cond,
  input  ctrl_pkg::pc_src_t  ex_pc_src,
  input  ctrl_pkg::brc_t     ex_brc,
  input  isa_pkg::word_t     ex_imm5_ext, ex_imm8_ext, ex_imm11_ext,
  input  isa_pkg::word_t     ex_pc, ex_rs_data, ex_rt_data,
  output logic               out_valid,
  output isa_pkg::word_t     result, set_val, next_pc,
  output logic               taken
);

  isa_pkg::word_t op_a, op_b, alu_out;
  isa_pkg::word_t pc_plus2, br_target, jmp_target, reg_target, target;
  logic           alu_zero, alu_cout, alu_ofl;
  logic           lt, cond_hit, br_hit, take;

  // Operand A, rs<<8 feeds SLBI
  always_comb begin
    case (ex_src_a)
      ctrl_pkg::SRC_RS_SHL8: op_a = {ex_rs_data[7:0], 8'h00};
      ctrl_pkg::SRC_ZERO:    op_a = '0;
      default:               op_a = ex_rs_data;
    endcase
  end

  // Operand B, register shifts take their amount from rt[3:0] inside the ALU
  always_comb begin
    case (ex_src_b)
      ctrl_pkg::SRC_IMM5: op_b = ex_imm5_ext;
      ctrl_pkg::SRC_IMM8: op_b = ex_imm8_ext;
      ctrl_pkg::SRC_ZERO: op_b = '0;
      default:            op_b = ex_rt_data;
    endcase
  end

  alu u_alu (
    .a     (op_a),
    .b     (op_b),
    .op    (ex_alu_op),
    .cin   (ex_cin),
    .inv_a (ex_inv_a),
    .inv_b (ex_inv_b),
    .sign  (1'b1),
    .out   (alu_out),
    .zero  (alu_zero),
    .cout  (alu_cout),
    .ofl   (alu_ofl)
  );

  // Signed less-than from rs - rt
  assign lt = alu_out[15] ^ alu_ofl;

  always_comb begin
    case (ex_cond)
      ctrl_pkg::COND_EQ: cond_hit = alu_zero;
      ctrl_pkg::COND_LT: cond_hit = lt;
      ctrl_pkg::COND_LE: cond_hit = lt | alu_zero;
      default:           cond_hit = alu_cout;
    endcase
  end

  always_comb begin
    case (ex_brc)
      ctrl_pkg::BRC_EQZ: br_hit = (ex_rs_data == '0);
      ctrl_pkg::BRC_NEZ: br_hit = (ex_rs_data != '0);
      ctrl_pkg::BRC_LTZ: br_hit = ex_rs_data[15];
      default:           br_hit = ~ex_rs_data[15];
    endcase
  end

  assign pc_plus2   = ex_pc + 16'd2;
  assign br_target  = pc_plus2 + ex_imm8_ext;
  assign jmp_target = pc_plus2 + ex_imm11_ext;
  assign reg_target = ex_rs_data + ex_imm8_ext;

  always_comb begin
    case (ex_pc_src)
      ctrl_pkg::PC_BR_IMM8: begin
        target = br_target;
        take   = ex_is_branch & br_hit;
      end
      ctrl_pkg::PC_JMP_IMM11: begin
        target = jmp_target;
        take   = 1'b1;
      end
      ctrl_pkg::PC_REG_IMM8: begin
        target = reg_target;
        take   = 1'b1;
      end
      default: begin
        target = pc_plus2;
        take   = 1'b0;
      end
    endcase
  end

  // Outputs hold between strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      result    <= '0;
      set_val   <= '0;
      next_pc   <= '0;
      taken     <= 1'b0;
    end else begin
      out_valid <= ex_valid;
      if (ex_valid) begin
        result  <= ex_active ? alu_out : '0;
        set_val <= isa_pkg::word_t'(ex_active & ex_is_set & cond_hit);
        next_pc <= take ? target : pc_plus2;
        taken   <= take;
      end
    end
  end

endmodule

`default_nettype wire

/* exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           in_valid,
  input  isa_pkg::word_t instr,
  input  isa_pkg::word_t pc,
  input  isa_pkg::word_t rs_data,
  input  isa_pkg::word_t rt_data,
  output logic           out_valid,
  output isa_pkg::word_t result,
  output isa_pkg::word_t set_val,
  output isa_pkg::word_t next_pc,
  output logic           taken
);

  // Decode outputs
  ctrl_pkg::alu_op_t  alu_op;
  ctrl_pkg::src_sel_t src_a, src_b;
  logic               cin, inv_a, inv_b, is_set, is_branch, active;
  ctrl_pkg::cond_t    cond;
  ctrl_pkg::pc_src_t  pc_src;
  ctrl_pkg::brc_t     brc;
  isa_pkg::word_t     imm5_ext, imm8_ext, imm11_ext;

  // Registered copies for the execute stage
  logic               ex_valid;
  ctrl_pkg::alu_op_t  ex_alu_op;
  ctrl_pkg::src_sel_t ex_src_a, ex_src_b;
  logic               ex_cin, ex_inv_a, ex_inv_b, ex_is_set, ex_is_branch, ex_active;
  ctrl_pkg::cond_t    ex_cond;
  ctrl_pkg::pc_src_t  ex_pc_src;
  ctrl_pkg::brc_t     ex_brc;
  isa_pkg::word_t     ex_imm5_ext, ex_imm8_ext, ex_imm11_ext;
  isa_pkg::word_t     ex_pc, ex_rs_data, ex_rt_data;

  // Port names line up across the three stages
  decode_ctrl u_decode (.*);

  id_ex_reg u_id_ex (.*);

  execution u_exec (.*);

endmodule

`default_nettype wire

/* tb_exec.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module tb_exec;

  logic           clk;
  logic           rst;
  logic           in_valid;
  isa_pkg::word_t instr;
  isa_pkg::word_t pc;
  isa_pkg::word_t rs_data;
  isa_pkg::word_t rt_data;
  logic           out_valid;
  isa_pkg::word_t result;
  isa_pkg::word_t set_val;
  isa_pkg::word_t next_pc;
  logic           taken;

  logic [31:0]    rng_state;
  int             mismatches;
  int             other_errors;
  int             sent_count;
  int             seen_count;

  // Expected outputs in the order they come back
  string          name_q[$];
  isa_pkg::word_t res_q[$];
  logic           res_chk_q[$];
  isa_pkg::word_t set_q[$];
  isa_pkg::word_t npc_q[$];
  logic           taken_q[$];

  // Opcodes that random bursts draw from
  isa_pkg::opcode_t subset [23] = '{
    isa_pkg::OPC_NOP, isa_pkg::OPC_J, isa_pkg::OPC_JR, isa_pkg::OPC_ADDI,
    isa_pkg::OPC_SUBI, isa_pkg::OPC_XORI, isa_pkg::OPC_ANDNI, isa_pkg::OPC_BEQZ,
    isa_pkg::OPC_BNEZ, isa_pkg::OPC_BLTZ, isa_pkg::OPC_BGEZ, isa_pkg::OPC_SLBI,
    isa_pkg::OPC_ROLI, isa_pkg::OPC_SLLI, isa_pkg::OPC_RORI, isa_pkg::OPC_SRLI,
    isa_pkg::OPC_LBI, isa_pkg::OPC_SHIFT, isa_pkg::OPC_ARITH, isa_pkg::OPC_SEQ,
    isa_pkg::OPC_SLT, isa_pkg::OPC_SLE, isa_pkg::OPC_SCO};
  isa_pkg::opcode_t imm_ops [6] = '{isa_pkg::OPC_ADDI, isa_pkg::OPC_SUBI,
    isa_pkg::OPC_XORI, isa_pkg::OPC_ANDNI, isa_pkg::OPC_LBI, isa_pkg::OPC_SLBI};
  isa_pkg::opcode_t shift_imm_ops [4] = '{isa_pkg::OPC_ROLI, isa_pkg::OPC_SLLI,
    isa_pkg::OPC_RORI, isa_pkg::OPC_SRLI};
  isa_pkg::opcode_t set_ops [4] = '{isa_pkg::OPC_SEQ, isa_pkg::OPC_SLT,
    isa_pkg::OPC_SLE, isa_pkg::OPC_SCO};
  isa_pkg::opcode_t branch_ops [4] = '{isa_pkg::OPC_BEQZ, isa_pkg::OPC_BNEZ,
    isa_pkg::OPC_BLTZ, isa_pkg::OPC_BGEZ};
  isa_pkg::opcode_t unknown_ops [6] = '{5'b00000, 5'b00010, 5'b00111, 5'b10000,
    5'b10011, 5'b11001};

  // Equal values, signed extremes and carry pairs
  isa_pkg::word_t cmp_a [10] = '{16'h1234, 16'h8000, 16'h7fff, 16'h8000, 16'h7fff,
    16'hffff, 16'h0001, 16'h8001, 16'h0000, 16'hfffe};
  isa_pkg::word_t cmp_b [10] = '{16'h1234, 16'h7fff, 16'h8000, 16'h8000, 16'h7fff,
    16'h0001, 16'hffff, 16'h8000, 16'h0000, 16'hffff};

  exec_top uut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .instr     (instr),
    .pc        (pc),
    .rs_data   (rs_data),
    .rt_data   (rt_data),
    .out_valid (out_valid),
    .result    (result),
    .set_val   (set_val),
    .next_pc   (next_pc),
    .taken     (taken)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic isa_pkg::word_t rand_word();
    logic [31:0] r;
    r = xorshift();
    return r[31:16] ^ r[15:0];
  endfunction

  function automatic isa_pkg::word_t rand_pc();
    isa_pkg::word_t w;
    w = rand_word();
    return {w[15:1], 1'b0};
  endfunction

  // Kind follows the function code order ROL, SLL, ROR, SRL
  function automatic isa_pkg::word_t shift_ref(input logic [1:0] kind,
                                               input isa_pkg::word_t v,
                                               input logic [3:0] n);
    case (kind)
      2'd0:    return (v << n) | (v >> (16 - n));
      2'd1:    return v << n;
      2'd2:    return (v >> n) | (v << (16 - n));
      default: return v >> n;
    endcase
  endfunction

  function automatic void ref_model(input isa_pkg::word_t ins, input isa_pkg::word_t pcv,
                                    input isa_pkg::word_t rs, input isa_pkg::word_t rt,
                                    output isa_pkg::word_t res, output logic chk,
                                    output isa_pkg::word_t setv,
                                    output isa_pkg::word_t npc, output logic tak);
    isa_pkg::word_t sx5, zx5, sx8, zx8, sx11, seq_pc;
    logic [16:0]    carry_sum;
    logic           hit;
    sx5       = {{11{ins[4]}}, ins[4:0]};
    zx5       = {11'd0, ins[4:0]};
    sx8       = {{8{ins[7]}}, ins[7:0]};
    zx8       = {8'd0, ins[7:0]};
    sx11      = {{5{ins[10]}}, ins[10:0]};
    seq_pc    = pcv + 16'd2;
    carry_sum = {1'b0, rs} + {1'b0, rt};
    res       = '0;
    chk       = 1'b1;
    setv      = '0;
    npc       = seq_pc;
    tak       = 1'b0;
    hit       = 1'b0;
    case (ins[15:11])
      isa_pkg::OPC_ARITH: begin
        case (ins[1:0])
          2'b00:   res = rs + rt;
          2'b01:   res = rt - rs;
          2'b10:   res = rs ^ rt;
          default: res = rs & ~rt;
        endcase
      end
      isa_pkg::OPC_ADDI:  res = rs + sx5;
      isa_pkg::OPC_SUBI:  res = sx5 - rs;
      isa_pkg::OPC_XORI:  res = rs ^ zx5;
      isa_pkg::OPC_ANDNI: res = rs & ~zx5;
      isa_pkg::OPC_SHIFT: res = shift_ref(ins[1:0], rs, rt[3:0]);
      isa_pkg::OPC_ROLI:  res = shift_ref(2'd0, rs, ins[3:0]);
      isa_pkg::OPC_SLLI:  res = shift_ref(2'd1, rs, ins[3:0]);
      isa_pkg::OPC_RORI:  res = shift_ref(2'd2, rs, ins[3:0]);
      isa_pkg::OPC_SRLI:  res = shift_ref(2'd3, rs, ins[3:0]);
      isa_pkg::OPC_LBI:   res = sx8;
      isa_pkg::OPC_SLBI:  res = (rs << 8) | zx8;
      isa_pkg::OPC_SEQ, isa_pkg::OPC_SLT, isa_pkg::OPC_SLE, isa_pkg::OPC_SCO: begin
        chk = 1'b0;
        case (ins[15:11])
          isa_pkg::OPC_SEQ: hit = (rs == rt);
          isa_pkg::OPC_SLT: hit = ($signed(rs) < $signed(rt));
          isa_pkg::OPC_SLE: hit = ($signed(rs) <= $signed(rt));
          default:          hit = carry_sum[16];
        endcase
        setv = {15'd0, hit};
      end
      isa_pkg::OPC_BEQZ, isa_pkg::OPC_BNEZ, isa_pkg::OPC_BLTZ, isa_pkg::OPC_BGEZ: begin
        chk = 1'b0;
        case (ins[15:11])
          isa_pkg::OPC_BEQZ: hit = (rs == 16'd0);
          isa_pkg::OPC_BNEZ: hit = (rs != 16'd0);
          isa_pkg::OPC_BLTZ: hit = rs[15];
          default:           hit = !rs[15];
        endcase
        if (hit) begin
          npc = seq_pc + sx8;
          tak = 1'b1;
        end
      end
      isa_pkg::OPC_J: begin
        chk = 1'b0;
        npc = seq_pc + sx11;
        tak = 1'b1;
      end
      isa_pkg::OPC_JR: begin
        chk = 1'b0;
        npc = rs + sx8;
        tak = 1'b1;
      end
      default: res = '0;
    endcase
  endfunction

  task automatic check_field(input string test, input string field,
                             input isa_pkg::word_t exp, input isa_pkg::word_t act);
    assert (exp === act) else begin
      mismatches++;
      $display("MISMATCH %s %s: expected %h, actual %h", test, field, exp, act);
    end
  endtask

  task automatic check_quiet(input string test);
    check_field(test, "out_valid", 16'd0, {15'd0, out_valid});
    check_field(test, "result", 16'd0, result);
    check_field(test, "set_val", 16'd0, set_val);
    check_field(test, "next_pc", 16'd0, next_pc);
    check_field(test, "taken", 16'd0, {15'd0, taken});
  endtask

  // Holds one strobe from this falling edge to the next
  task automatic send(input string test, input isa_pkg::word_t ins, input isa_pkg::word_t pcv,
                      input isa_pkg::word_t rs, input isa_pkg::word_t rt);
    isa_pkg::word_t res, setv, npc;
    logic           chk, tak;
    ref_model(ins, pcv, rs, rt, res, chk, setv, npc, tak);
    name_q.push_back(test);
    res_q.push_back(res);
    res_chk_q.push_back(chk);
    set_q.push_back(setv);
    npc_q.push_back(npc);
    taken_q.push_back(tak);
    instr    = ins;
    pc       = pcv;
    rs_data  = rs;
    rt_data  = rt;
    in_valid = 1'b1;
    sent_count++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_outputs(input string test);
    int cycles;
    cycles = 0;
    while (name_q.size() != 0 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (name_q.size() != 0) begin
      other_errors++;
      $display("Timeout in %s: %0d expected outputs never arrived", test, name_q.size());
      name_q.delete();
      res_q.delete();
      res_chk_q.delete();
      set_q.delete();
      npc_q.delete();
      taken_q.delete();
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin : out_checker
    string          tname;
    isa_pkg::word_t exp_res, exp_set, exp_npc;
    logic           exp_chk, exp_tak;
    if (!rst && out_valid) begin
      seen_count++;
      if (name_q.size() == 0) begin
        other_errors++;
        $display("out_valid was high with no instruction outstanding at %0t", $time);
      end else begin
        tname   = name_q.pop_front();
        exp_res = res_q.pop_front();
        exp_chk = res_chk_q.pop_front();
        exp_set = set_q.pop_front();
        exp_npc = npc_q.pop_front();
        exp_tak = taken_q.pop_front();
        if (exp_chk) begin
          check_field(tname, "result", exp_res, result);
        end
        check_field(tname, "set_val", exp_set, set_val);
        check_field(tname, "next_pc", exp_npc, next_pc);
        check_field(tname, "taken", {15'd0, exp_tak}, {15'd0, taken});
      end
    end
  end

  latency_check: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, `EXEC_LATENCY))
    else begin
      other_errors++;
      $display("out_valid did not follow in_valid by %0d cycles at %0t",
               `EXEC_LATENCY, $time);
    end

  initial begin
    isa_pkg::word_t w;
    isa_pkg::word_t v;
    int             burst_start;
    clk          = 1'b0;
    rst          = 1'b1;
    in_valid     = 1'b0;
    instr        = '0;
    pc           = '0;
    rs_data      = '0;
    rt_data      = '0;
    rng_state    = 32'd59;
    mismatches   = 0;
    other_errors = 0;
    sent_count   = 0;
    seen_count   = 0;

    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      check_quiet("reset");
    end
    rst = 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_quiet("idle");
    end

    // Register ops first, then the immediate forms and byte loads
    for (int k = 0; k < 10; k++) begin
      for (int j = 0; j < 6; j++) begin
        w = rand_word();
        if (k < 4) begin
          send("arith", {isa_pkg::OPC_ARITH, w[10:2], k[1:0]}, rand_pc(), rand_word(),
               rand_word());
        end else begin
          send("arith_imm", {imm_ops[k-4], w[10:0]}, rand_pc(), rand_word(), rand_word());
        end
      end
    end
    wait_outputs("arith");

    for (int k = 0; k < 4; k++) begin
      for (int n = 0; n < 16; n++) begin
        w = rand_word();
        v = rand_word();
        send("shift_reg", {isa_pkg::OPC_SHIFT, v[10:2], k[1:0]}, rand_pc(), rand_word(),
             {w[15:4], n[3:0]});
        send("shift_imm", {shift_imm_ops[k], v[10:4], n[3:0]}, rand_pc(), rand_word(), w);
      end
    end
    wait_outputs("shift");

    for (int k = 0; k < 4; k++) begin
      for (int j = 0; j < 14; j++) begin
        w = rand_word();
        if (j < 10) begin
          send("set_cond", {set_ops[k], w[10:0]}, rand_pc(), cmp_a[j], cmp_b[j]);
        end else begin
          send("set_cond_rand", {set_ops[k], w[10:0]}, rand_pc(), rand_word(), rand_word());
        end
      end
    end
    wait_outputs("set_cond");

    // rs zero, positive and negative for every branch test
    for (int k = 0; k < 4; k++) begin
      for (int j = 0; j < 2; j++) begin
        w = rand_word();
        v = rand_word();
        send("branch_zero", {branch_ops[k], w[10:0]}, rand_pc(), 16'd0, rand_word());
        send("branch_pos", {branch_ops[k], w[10:0]}, rand_pc(), {1'b0, v[14:1], 1'b1},
             rand_word());
        send("branch_neg", {branch_ops[k], w[10:0]}, rand_pc(), {1'b1, v[14:0]},
             rand_word());
      end
    end
    for (int j = 0; j < 4; j++) begin
      w = rand_word();
      send("jump", {isa_pkg::OPC_J, w[10:0]}, rand_pc(), rand_word(), rand_word());
      send("jump_reg", {isa_pkg::OPC_JR, w[10:0]}, rand_pc(), rand_word(), rand_word());
    end
    w = rand_word();
    send("nop", {isa_pkg::OPC_NOP, w[10:0]}, rand_pc(), rand_word(), rand_word());
    for (int k = 0; k < 6; k++) begin
      w = rand_word();
      send("unknown_opcode", {unknown_ops[k], w[10:0]}, rand_pc(), rand_word(), rand_word());
    end
    wait_outputs("control_flow");

    burst_start = seen_count;
    for (int j = 0; j < 40; j++) begin
      w = rand_word();
      v = rand_word();
      send("burst", {subset[v % 23], w[10:0]}, rand_pc(), rand_word(), rand_word());
    end
    wait_outputs("burst");
    if (seen_count - burst_start != 40) begin
      other_errors++;
      $display("Burst of 40 instructions produced %0d outputs", seen_count - burst_start);
    end

    if (seen_count != sent_count) begin
      other_errors++;
      $display("Sent %0d instructions but saw %0d outputs", sent_count, seen_count);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
alu.sv
decode_ctrl.sv
id_ex_reg.sv
execution.sv
exec_top.sv
tb_exec.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench and DUT with Verilator, then run and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module tb_exec &&
  ./obj_dir/Vtb_exec | tee /dev/stderr | grep -qx "PASS: all tests" &&
  echo "run_sim: simulation passed" ||
  { echo "run_sim: simulation failed"; exit 1; }
